//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fp_mul
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "Verification failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- build.f
hdl/fp_mul_pkg.sv
hdl/booth_multiplier.sv
hdl/fp_normalizer.sv
hdl/fp_rounder.sv
hdl/fp_mul.sv
test/fp_mul_checker.sv
test/tb_fp_mul.sv

//--- hdl/booth_multiplier.sv
`timescale 1ns/10ps

module booth_multiplier #(
    parameter int WIDTH = 24
) (
    input  logic [WIDTH-1:0]   a,
    input  logic [WIDTH-1:0]   b,
    output logic [2*WIDTH-1:0] product
);

    // enough digits that the top group always sees a zero msb
    localparam int NDIG = WIDTH / 2 + 1;
    // partial product width, room for 2a plus sign
    localparam int PW = WIDTH + 2;
    localparam int OW = 2 * WIDTH;

    // b with an implicit zero below bit 0 and zero padding on top
    logic [2*NDIG:0] b_ext;

    // recoded digit controls
    logic [NDIG-1:0] dig_neg;
    logic [NDIG-1:0] dig_one;
    logic [NDIG-1:0] dig_two;

    logic [PW-1:0] a_x1;
    logic [PW-1:0] a_x2;

    logic [NDIG-1:0][PW-1:0] pp;

    logic [OW-1:0] acc;

    assign b_ext = {{(2*NDIG-WIDTH){1'b0}}, b, 1'b0};

    assign a_x1 = {2'b00, a};
    assign a_x2 = {1'b0, a, 1'b0};

    genvar i;
    generate
        for (i = 0; i < NDIG; i++) begin : g_digit
            logic [2:0] grp;
            logic [PW-1:0] mag;

            assign grp = b_ext[2*i +: 3];

            // digit = -2*b[2i+1] + b[2i] + b[2i-1]
            assign dig_one[i] = grp[1] ^ grp[0];
            assign dig_two[i] = (grp == 3'b100) || (grp == 3'b011);
            assign dig_neg[i] = grp[2] && !(grp[1] && grp[0]);

            assign mag = dig_one[i] ? a_x1 : (dig_two[i] ? a_x2 : '0);

            // two's complement of the magnitude for negative digits
            assign pp[i] = dig_neg[i] ? (~mag + 1'b1) : mag;
        end
    endgenerate

    // weighted sum, each row sign extended to the full width
    always_comb begin
        acc = '0;
        for (int k = 0; k < NDIG; k++) begin
            acc = acc + ({{(OW-PW){pp[k][PW-1]}}, pp[k]} << (2 * k));
        end
    end

    // true product is non-negative and fits, wrap of the sum is harmless
    assign product = acc;

endmodule

//--- hdl/fp_mul.sv
`timescale 1ns/10ps

module fp_mul #(
    parameter int SIG_W_P = fp_mul_pkg::SIG_W
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  logic [31:0]             fp_x,
    input  logic [31:0]             fp_y,
    input  fp_mul_pkg::round_mode_e r_mode,
    output logic                    out_valid,
    output logic [31:0]             fp_z,
    output logic                    ovrf,
    output logic                    udrf
);

    localparam int EXP_W = fp_mul_pkg::EXP_W;
    localparam int FRAC_W = fp_mul_pkg::FRAC_W;
    localparam int XW = EXP_W + 3;

    localparam logic [EXP_W-1:0] EXP_ONES = '1;
    localparam logic signed [XW-1:0] BIAS_S = XW'(fp_mul_pkg::EXP_BIAS);
    localparam logic signed [XW-1:0] EXP_MAX_S = {3'b000, EXP_ONES};
    localparam logic signed [XW-1:0] EXP_MIN_S = XW'(1);

    // result class
    localparam logic [1:0] CLS_NORM = 2'd0;
    localparam logic [1:0] CLS_ZERO = 2'd1;
    localparam logic [1:0] CLS_INF = 2'd2;
    localparam logic [1:0] CLS_NAN = 2'd3;

    logic [EXP_W-1:0]      exp_x;
    logic [EXP_W-1:0]      exp_y;
    logic [FRAC_W-1:0]     frac_x;
    logic [FRAC_W-1:0]     frac_y;
    logic                  zero_x;
    logic                  zero_y;
    logic                  inf_x;
    logic                  inf_y;
    logic                  nan_x;
    logic                  nan_y;
    logic [SIG_W_P-1:0]    sig_x;
    logic [SIG_W_P-1:0]    sig_y;
    logic [2*SIG_W_P-1:0]  prod_s1;
    logic [1:0]            cls_s1;

    // stage 1 registers
    logic                  vld_s1;
    logic [2*SIG_W_P-1:0]  frc_z_full;
    logic                  sign_z;
    logic [EXP_W:0]        exp_sum;
    fp_mul_pkg::round_mode_e r_mode_q;
    logic [1:0]            cls_q;

    // stage 2
    logic [fp_mul_pkg::NORM_W-1:0] frc_z_norm;
    logic                  norm_n;
    logic [FRAC_W-1:0]     frc_z;
    logic                  norm_r;
    logic signed [XW-1:0]  exp_z;
    logic [31:0]           fp_z_d;
    logic                  ovrf_d;
    logic                  udrf_d;

    assign exp_x = fp_x[30:FRAC_W];
    assign exp_y = fp_y[30:FRAC_W];
    assign frac_x = fp_x[FRAC_W-1:0];
    assign frac_y = fp_y[FRAC_W-1:0];

    // subnormals flush to zero
    assign zero_x = (exp_x == '0);
    assign zero_y = (exp_y == '0);
    assign inf_x = (exp_x == EXP_ONES) && (frac_x == '0);
    assign inf_y = (exp_y == EXP_ONES) && (frac_y == '0);
    assign nan_x = (exp_x == EXP_ONES) && (frac_x != '0);
    assign nan_y = (exp_y == EXP_ONES) && (frac_y != '0);

    assign sig_x = {!zero_x, frac_x};
    assign sig_y = {!zero_y, frac_y};

    booth_multiplier #(
        .WIDTH(SIG_W_P)
    ) booth_multiplier_inst (
        .a(sig_x),
        .b(sig_y),
        .product(prod_s1)
    );

    always_comb begin
        if (nan_x || nan_y || (inf_x && zero_y) || (inf_y && zero_x)) begin
            cls_s1 = CLS_NAN;
        end else if (inf_x || inf_y) begin
            cls_s1 = CLS_INF;
        end else if (zero_x || zero_y) begin
            cls_s1 = CLS_ZERO;
        end else begin
            cls_s1 = CLS_NORM;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_s1 <= 1'b0;
        end else begin
            vld_s1 <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            frc_z_full <= prod_s1;
            sign_z <= fp_x[31] ^ fp_y[31];
            exp_sum <= {1'b0, exp_x} + {1'b0, exp_y};
            r_mode_q <= r_mode;
            cls_q <= cls_s1;
        end
    end

    fp_normalizer fp_normalizer_inst (
        .frc_z_full(frc_z_full),
        .frc_z_norm(frc_z_norm),
        .norm_n(norm_n)
    );

    fp_rounder fp_rounder_inst (
        .frc_z_norm(frc_z_norm),
        .r_mode(r_mode_q),
        .sign_z(sign_z),
        .frc_z(frc_z),
        .norm_r(norm_r)
    );

    // both normalization steps can bump the exponent
    assign exp_z = $signed({2'b00, exp_sum}) - BIAS_S
                 + $signed({{(XW-1){1'b0}}, norm_n})
                 + $signed({{(XW-1){1'b0}}, norm_r});

    always_comb begin
        fp_z_d = {sign_z, exp_z[EXP_W-1:0], frc_z};
        ovrf_d = 1'b0;
        udrf_d = 1'b0;
        case (cls_q)
            CLS_NAN: begin
                fp_z_d = fp_mul_pkg::QNAN;
            end
            CLS_INF: begin
                fp_z_d = {sign_z, EXP_ONES, {FRAC_W{1'b0}}};
            end
            CLS_ZERO: begin
                fp_z_d = {sign_z, {(EXP_W+FRAC_W){1'b0}}};
            end
            default: begin
                if (exp_z >= EXP_MAX_S) begin
                    fp_z_d = {sign_z, EXP_ONES, {FRAC_W{1'b0}}};
                    ovrf_d = 1'b1;
                end else if (exp_z < EXP_MIN_S) begin
                    // no subnormal results
                    fp_z_d = {sign_z, {(EXP_W+FRAC_W){1'b0}}};
                    udrf_d = 1'b1;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            fp_z <= '0;
            ovrf <= 1'b0;
            udrf <= 1'b0;
        end else begin
            out_valid <= vld_s1;
            if (vld_s1) begin
                fp_z <= fp_z_d;
                ovrf <= ovrf_d;
                udrf <= udrf_d;
            end
        end
    end

endmodule

//--- hdl/fp_mul_pkg.sv
package fp_mul_pkg;

    // single precision field widths
    localparam int FRAC_W = 23;
    localparam int EXP_W = 8;
    localparam int EXP_BIAS = 127;

    // significand with hidden bit
    localparam int SIG_W = FRAC_W + 1;

    // hidden bit, fraction, one extra bit, guard and sticky
    localparam int NORM_W = SIG_W + 3;

    // quiet NaN returned for every invalid operation
    localparam logic [31:0] QNAN = 32'h7fc0_0000;

    typedef enum logic [2:0] {
        // nearest, ties to even
        RNE = 3'b000,
        // toward zero
        RTZ = 3'b001,
        // toward minus infinity
        RDN = 3'b010,
        // toward plus infinity
        RUP = 3'b011,
        // nearest, ties away from zero
        RMM = 3'b100
    } round_mode_e;

endpackage

//--- hdl/fp_normalizer.sv
`timescale 1ns/10ps

module fp_normalizer (
    input  logic [2*fp_mul_pkg::SIG_W-1:0] frc_z_full,
    output logic [fp_mul_pkg::NORM_W-1:0]  frc_z_norm,
    output logic                           norm_n
);

    localparam int PROD_W = 2 * fp_mul_pkg::SIG_W;
    // bits kept above the sticky position
    localparam int KEEP_W = fp_mul_pkg::NORM_W - 1;
    // bits folded into sticky
    localparam int DROP_W = PROD_W - KEEP_W;

    logic [PROD_W-1:0] prod_sh;
    logic              sticky;

    // product of two values in [1,2) lies in [1,4)
    assign norm_n = frc_z_full[PROD_W-1];

    // leading one into the top bit
    assign prod_sh = norm_n ? frc_z_full : {frc_z_full[PROD_W-2:0], 1'b0};

    assign sticky = |prod_sh[DROP_W-1:0];

    assign frc_z_norm = {prod_sh[PROD_W-1:DROP_W], sticky};

endmodule

//--- hdl/fp_rounder.sv
`timescale 1ns/10ps

module fp_rounder (
    input  logic [fp_mul_pkg::NORM_W-1:0] frc_z_norm,
    input  fp_mul_pkg::round_mode_e       r_mode,
    input  logic                          sign_z,
    output logic [fp_mul_pkg::FRAC_W-1:0] frc_z,
    output logic                          norm_r
);

    localparam int SIG_W = fp_mul_pkg::SIG_W;

    // hidden bit plus kept fraction
    logic [SIG_W-1:0] sig_keep;
    logic             rnd_bit;
    logic             stk_bit;
    logic             inexact;
    logic             inc;

    logic [SIG_W:0]   sig_sum;

    assign sig_keep = frc_z_norm[fp_mul_pkg::NORM_W-1:3];
    assign rnd_bit = frc_z_norm[2];
    assign stk_bit = |frc_z_norm[1:0];
    assign inexact = rnd_bit || stk_bit;

    always_comb begin
        case (r_mode)
            fp_mul_pkg::RNE: begin
                // tie goes to the even neighbour
                inc = rnd_bit && (stk_bit || frc_z_norm[3]);
            end
            fp_mul_pkg::RTZ: begin
                inc = 1'b0;
            end
            fp_mul_pkg::RDN: begin
                inc = sign_z && inexact;
            end
            fp_mul_pkg::RUP: begin
                inc = !sign_z && inexact;
            end
            fp_mul_pkg::RMM: begin
                inc = rnd_bit;
            end
            default: begin
                inc = 1'b0;
            end
        endcase
    end

    assign sig_sum = {1'b0, sig_keep} + {{SIG_W{1'b0}}, inc};

    // carry out means 1.111..1 rolled over to 10.000..0
    assign norm_r = sig_sum[SIG_W];
    assign frc_z = sig_sum[fp_mul_pkg::FRAC_W-1:0];

endmodule

//--- test/fp_mul_checker.sv
`timescale 1ns/10ps

module fp_mul_checker (
    input  logic                                clk,
    input  logic                                in_valid,
    input  logic [fp_mul_pkg::SIG_W-1:0]        sig_x,
    input  logic [fp_mul_pkg::SIG_W-1:0]        sig_y,
    input  logic                                vld_s1,
    input  logic [2*fp_mul_pkg::SIG_W-1:0]      frc_z_full,
    input  logic [fp_mul_pkg::NORM_W-1:0]       frc_z_norm,
    input  logic                                norm_n,
    input  logic [fp_mul_pkg::FRAC_W-1:0]       frc_z,
    input  logic                                norm_r,
    input  logic                                sign_z,
    input  fp_mul_pkg::round_mode_e             r_mode,
    output int                                  errors
);

    localparam int SW = fp_mul_pkg::SIG_W;

    logic [2*SW-1:0] prod_ref;
    logic [25:0]     upper_ref;
    logic            stk_ref;
    logic [SW-1:0]   keep;
    logic            rnd;
    logic            stk;
    logic            inc;
    logic [SW:0]     sum;
    int              err_cnt = 0;

    assign errors = err_cnt;

    // exact product of the operands sampled with the pair
    always @(posedge clk) begin
        if (in_valid) begin
            prod_ref <= {{SW{1'b0}}, sig_x} * {{SW{1'b0}}, sig_y};
        end
    end

    // stage 2 is settled by the falling edge
    always @(negedge clk) begin
        if (vld_s1) begin
            assert (frc_z_full == prod_ref) else begin
                $display("** Error: frc_z_full = %h, expected %h", frc_z_full, prod_ref);
                err_cnt++;
            end
            assert (norm_n == frc_z_full[47]) else begin
                $display("** Error: norm_n = %h, expected %h", norm_n, frc_z_full[47]);
                err_cnt++;
            end

            upper_ref = norm_n ? frc_z_full[47:22] : frc_z_full[46:21];
            stk_ref = norm_n ? |frc_z_full[21:0] : |frc_z_full[20:0];
            assert (frc_z_norm[26:1] == upper_ref) else begin
                $display("** Error: frc_z_norm[26:1] = %h, expected %h",
                         frc_z_norm[26:1], upper_ref);
                err_cnt++;
            end
            assert (frc_z_norm[0] == stk_ref) else begin
                $display("** Error: sticky = %h, expected %h", frc_z_norm[0], stk_ref);
                err_cnt++;
            end

            keep = frc_z_norm[26:3];
            rnd = frc_z_norm[2];
            stk = |frc_z_norm[1:0];
            case (r_mode)
                fp_mul_pkg::RNE: inc = rnd && (stk || keep[0]);
                fp_mul_pkg::RDN: inc = sign_z && (rnd || stk);
                fp_mul_pkg::RUP: inc = !sign_z && (rnd || stk);
                fp_mul_pkg::RMM: inc = rnd;
                default: inc = 1'b0;
            endcase
            sum = {1'b0, keep} + {{SW{1'b0}}, inc};
            assert ({norm_r, frc_z} == {sum[SW], sum[SW-2:0]}) else begin
                $display("** Error: {norm_r, frc_z} = %h, expected %h, r_mode %0d",
                         {norm_r, frc_z}, {sum[SW], sum[SW-2:0]}, r_mode);
                err_cnt++;
            end
            assert (!norm_r || (&keep)) else begin
                $display("norm_r set although the kept bits %h were not all ones", keep);
                err_cnt++;
            end
        end
    end

endmodule

//--- test/tb_fp_mul.sv
`timescale 1ns/10ps

module tb_fp_mul;

    localparam int CLK_PERIOD = 20;
    localparam int N_RAND = 200;
    // directed pairs plus idle and drain cycles, rounded up
    localparam int N_DIRECTED = 100;
    localparam int TIMEOUT_NS = (N_RAND + N_DIRECTED + 20) * CLK_PERIOD;

    typedef struct packed {
        logic [31:0]             x;
        logic [31:0]             y;
        fp_mul_pkg::round_mode_e mode;
        logic [31:0]             z;
        logic                    ov;
        logic                    ud;
        logic [31:0]             cyc;
    } pending_t;

    logic                    clk;
    logic                    rst_n;
    logic                    in_valid;
    logic [31:0]             fp_x;
    logic [31:0]             fp_y;
    fp_mul_pkg::round_mode_e r_mode;
    logic                    out_valid;
    logic [31:0]             fp_z;
    logic                    ovrf;
    logic                    udrf;

    pending_t    exp_q[$];
    int          seed;
    int unsigned cyc = 0;
    int          mon_errors = 0;
    int          seq_errors = 0;
    int          chk_errors;
    int          tests_passed = 0;
    int          tests_failed = 0;

    fp_mul #(
        .SIG_W_P(fp_mul_pkg::SIG_W)
    ) fp_mul_inst (
        .clk(clk),
        .rst_n(rst_n),
        .in_valid(in_valid),
        .fp_x(fp_x),
        .fp_y(fp_y),
        .r_mode(r_mode),
        .out_valid(out_valid),
        .fp_z(fp_z),
        .ovrf(ovrf),
        .udrf(udrf)
    );

    fp_mul_checker fp_mul_checker_inst (
        .clk(clk),
        .in_valid(in_valid),
        .sig_x(fp_mul_inst.sig_x),
        .sig_y(fp_mul_inst.sig_y),
        .vld_s1(fp_mul_inst.vld_s1),
        .frc_z_full(fp_mul_inst.frc_z_full),
        .frc_z_norm(fp_mul_inst.frc_z_norm),
        .norm_n(fp_mul_inst.norm_n),
        .frc_z(fp_mul_inst.frc_z),
        .norm_r(fp_mul_inst.norm_r),
        .sign_z(fp_mul_inst.sign_z),
        .r_mode(fp_mul_inst.r_mode_q),
        .errors(chk_errors)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // {ovrf, udrf, fp_z} from the field rules
    function automatic logic [33:0] expected_result(input logic [31:0] x, input logic [31:0] y,
                                                    input fp_mul_pkg::round_mode_e mode);
        int          ex;
        int          ey;
        int          e;
        logic        sign;
        logic        zero_x;
        logic        zero_y;
        logic        inf_x;
        logic        inf_y;
        logic        nan_x;
        logic        nan_y;
        logic        inexact;
        logic        inc;
        logic [47:0] p;
        logic [24:0] m;
        ex = 32'(x[30:23]);
        ey = 32'(y[30:23]);
        sign = x[31] ^ y[31];
        zero_x = (ex == 0);
        zero_y = (ey == 0);
        inf_x = (ex == 255) && (x[22:0] == '0);
        inf_y = (ey == 255) && (y[22:0] == '0);
        nan_x = (ex == 255) && (x[22:0] != '0);
        nan_y = (ey == 255) && (y[22:0] != '0);
        if (nan_x || nan_y || (inf_x && zero_y) || (inf_y && zero_x)) begin
            return {2'b00, fp_mul_pkg::QNAN};
        end
        if (inf_x || inf_y) begin
            return {2'b00, sign, 8'hff, 23'd0};
        end
        if (zero_x || zero_y) begin
            return {2'b00, sign, 31'd0};
        end
        p = 48'({1'b1, x[22:0]}) * 48'({1'b1, y[22:0]});
        e = ex + ey - 127;
        if (p[47]) begin
            e = e + 1;
        end else begin
            p = p << 1;
        end
        inexact = |p[23:0];
        case (mode)
            fp_mul_pkg::RNE: inc = p[23] && ((|p[22:0]) || p[24]);
            fp_mul_pkg::RDN: inc = sign && inexact;
            fp_mul_pkg::RUP: inc = !sign && inexact;
            fp_mul_pkg::RMM: inc = p[23];
            default: inc = 1'b0;
        endcase
        m = {1'b0, p[47:24]} + {24'd0, inc};
        if (m[24]) begin
            e = e + 1;
        end
        if (e >= 255) begin
            return {2'b10, sign, 8'hff, 23'd0};
        end
        if (e < 1) begin
            return {2'b01, sign, 31'd0};
        end
        return {2'b00, sign, e[7:0], m[22:0]};
    endfunction

    function automatic int total_errors();
        return mon_errors + seq_errors + chk_errors;
    endfunction

    // one pair per call, result due two edges on
    task automatic send(input logic [31:0] x, input logic [31:0] y,
                        input fp_mul_pkg::round_mode_e mode);
        pending_t    p;
        logic [33:0] m;
        m = expected_result(x, y, mode);
        p.x = x;
        p.y = y;
        p.mode = mode;
        p.z = m[31:0];
        p.ov = m[33];
        p.ud = m[32];
        p.cyc = cyc + 2;
        exp_q.push_back(p);
        in_valid = 1'b1;
        fp_x = x;
        fp_y = y;
        r_mode = mode;
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    task automatic rand_operand(input logic [7:0] exp_lo, input logic [6:0] span,
                                output logic [31:0] v);
        logic [31:0] r;
        r = $random(seed);
        v = {r[31], exp_lo + {1'b0, r[30:24] & span}, r[22:0]};
    endtask

    task automatic drain();
        in_valid = 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
        @(posedge clk);
        #2;
    endtask

    task automatic end_test(input string name, input int start_errors);
        int n;
        n = total_errors() - start_errors;
        if (n == 0) begin
            tests_passed++;
            $display("test %-12s ok", name);
        end else begin
            tests_failed++;
            $display("test %-12s %0d errors", name, n);
        end
    endtask

    // scoreboard
    initial begin
        pending_t p;
        forever begin
            @(negedge clk);
            if (rst_n && out_valid) begin
                if (exp_q.size() == 0) begin
                    $display("out_valid high with no result pending at %0t", $time);
                    mon_errors++;
                end else begin
                    p = exp_q.pop_front();
                    assert (cyc == p.cyc) else begin
                        $display("result for %h * %h came in cycle %0d instead of cycle %0d",
                                 p.x, p.y, cyc, p.cyc);
                        mon_errors++;
                    end
                    assert (fp_z == p.z) else begin
                        $display("** Error: fp_z = %h, expected %h, fp_x %h, fp_y %h, r_mode %0d",
                                 fp_z, p.z, p.x, p.y, p.mode);
                        mon_errors++;
                    end
                    assert (ovrf == p.ov && udrf == p.ud) else begin
                        $display("** Error: {ovrf, udrf} expected %h, actual %h, fp_x %h, fp_y %h",
                                 {p.ov, p.ud}, {ovrf, udrf}, p.x, p.y);
                        mon_errors++;
                    end
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timed out after %0d ns with %0d results pending", TIMEOUT_NS, exp_q.size());
        $display("Verification failed");
        $finish;
    end

    initial begin
        int          start;
        int          k;
        logic [31:0] a;
        logic [31:0] b;
        logic [33:0] m;
        seed = 21;
        rst_n = 1'b0;
        in_valid = 1'b0;
        fp_x = '0;
        fp_y = '0;
        r_mode = fp_mul_pkg::RNE;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        start = total_errors();
        repeat (4) begin
            @(negedge clk);
            assert (!out_valid && !ovrf && !udrf && fp_z == '0) else begin
                $display("** Error: out_valid %h ovrf %h udrf %h fp_z %h after reset, expected 0",
                         out_valid, ovrf, udrf, fp_z);
                seq_errors++;
            end
        end
        @(posedge clk);
        #2;
        end_test("reset", start);

        start = total_errors();
        m = expected_result(32'h4040_0000, 32'h4040_0000, fp_mul_pkg::RTZ);
        assert (m[31:0] == 32'h4110_0000) else begin
            $display("** Error: model fp_z = %h, expected 41100000", m[31:0]);
            seq_errors++;
        end
        send(32'h4040_0000, 32'h4040_0000, fp_mul_pkg::RTZ);
        for (k = 0; k < N_RAND; k++) begin
            rand_operand(8'd64, 7'h7f, a);
            rand_operand(8'd64, 7'h7f, b);
            send(a, b, fp_mul_pkg::round_mode_e'(3'(k % 5)));
        end
        drain();
        end_test("random", start);

        // zeros, subnormals, infinities and NaNs
        start = total_errors();
        send(32'h0000_0000, 32'h4040_0000, fp_mul_pkg::RNE);
        send(32'h8000_0000, 32'h4040_0000, fp_mul_pkg::RUP);
        send(32'h0040_0000, 32'hc000_0000, fp_mul_pkg::RDN);
        send(32'h7f80_0000, 32'hc000_0000, fp_mul_pkg::RNE);
        send(32'hff80_0000, 32'hff80_0000, fp_mul_pkg::RTZ);
        send(32'h7f80_0000, 32'h0000_0000, fp_mul_pkg::RNE);
        send(32'h0000_0001, 32'hff80_0000, fp_mul_pkg::RMM);
        send(32'h7fc0_0001, 32'h3f80_0000, fp_mul_pkg::RNE);
        send(32'h3f80_0000, 32'hff81_2345, fp_mul_pkg::RUP);
        drain();
        end_test("special", start);

        start = total_errors();
        send(32'h7f00_0000, 32'h7f00_0000, fp_mul_pkg::RNE);
        send(32'hc000_0000, 32'h7f7f_ffff, fp_mul_pkg::RTZ);
        send(32'h0080_0000, 32'h0080_0000, fp_mul_pkg::RNE);
        send(32'h8080_0000, 32'h3f00_0000, fp_mul_pkg::RUP);
        for (k = 0; k < 10; k++) begin
            rand_operand(8'd200, 7'h1f, a);
            rand_operand(8'd200, 7'h1f, b);
            send(a, b, fp_mul_pkg::round_mode_e'(3'(k % 5)));
            rand_operand(8'd1, 7'h1f, a);
            rand_operand(8'd1, 7'h1f, b);
            send(a, b, fp_mul_pkg::round_mode_e'(3'(k % 5)));
        end
        drain();
        end_test("range", start);

        // significand product 2^47 - 2, kept bits all ones with round and sticky set
        start = total_errors();
        send(32'h3fff_fffe, 32'h3f80_0001, fp_mul_pkg::RNE);
        send(32'h3fff_fffe, 32'h3f80_0001, fp_mul_pkg::RUP);
        send(32'hbfff_fffe, 32'h3f80_0001, fp_mul_pkg::RDN);
        send(32'h3f7f_fffe, 32'h3f80_0001, fp_mul_pkg::RMM);
        drain();
        end_test("round carry", start);

        start = total_errors();
        for (k = 0; k < 12; k++) begin
            if (k == 8) begin
                @(posedge clk);
                #2;
            end
            rand_operand(8'd64, 7'h7f, a);
            rand_operand(8'd64, 7'h7f, b);
            send(a, b, fp_mul_pkg::round_mode_e'(3'(k % 5)));
        end
        drain();
        end_test("back to back", start);

        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
